//--- adc_pkg.sv
// shared widths, register map and engine states for the serial ADC controller, imported by every module
package adc_pkg;

  // ----------------------------------------
  // widths that carry a meaning
  typedef logic [15:0] word_t;     // adc word, bus data, config value
  typedef logic [2:0]  chan_t;     // channel index
  typedef logic [11:0] reg_addr_t; // wishbone word address
  typedef logic [15:0] seq_t;      // per-channel sequence number

  localparam int NUM_CHANNELS = 8;

  // ----------------------------------------
  // register offsets, adr[3:0]
  localparam logic [3:0] REG_OVERFLOW = 4'd1;  // per-channel sample period, rw
  localparam logic [3:0] REG_DIVIDE   = 4'd2;  // sclk half-period minus one, rw
  localparam logic [3:0] REG_PROGRAM  = 4'd4;  // program word, write only
  localparam logic [3:0] REG_SAMPLE   = 4'd7;  // published sample, ro
  localparam logic [3:0] REG_SEQUENCE = 4'd8;  // sample sequence number, ro
  localparam logic [3:0] REG_ID       = 4'd9;  // fixed identifier
  localparam logic [3:0] REG_BUSY     = 4'd10; // bit 0 set while a program word is outstanding
  localparam logic [3:0] REG_LAST     = 4'd11; // last program word sent to the chip

  localparam word_t ADC_ID = 16'h0ADC;

  // ----------------------------------------
  // frame engine states
  typedef enum logic [2:0] {
    IDLE,      // cs_n high, waiting for a falling sclk tick
    PROGRAM,   // shifting the pending word out on din
    CONVERT,   // shifting a conversion result in from dout
    COPY,      // hand the received word to the sample store
    WRITEBACK  // record the word that was just sent
  } frame_state_t;

endpackage

//--- adc_bus_regs.sv
// wishbone classic register block, holds the configuration and returns status and samples on reads
`timescale 1ns/1ns

module adc_bus_regs import adc_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  // wishbone slave
  input  logic      cyc,
  input  logic      stb,
  input  logic      we,
  input  reg_addr_t adr,
  input  word_t     dat_w,
  output logic      ack,
  output word_t     dat_r,
  // frame engine
  output word_t     cmd_word,
  output logic      cmd_load,
  output word_t     clk_div,
  input  logic      busy,
  input  word_t     last_cmd,
  // sample store
  output logic      ovf_write,
  output chan_t     ovf_chan,
  output word_t     ovf_value,
  output chan_t     rd_chan,
  input  word_t     rd_sample,
  input  seq_t      rd_seq
);

  logic       req;       // first cycle of an access
  logic       chan_ok;   // channel field inside 0..7
  logic       wr;        // accepted write
  logic [3:0] offset;
  word_t      rd_data;   // read mux, registered into dat_r
  word_t      ovf_copy [NUM_CHANNELS]; // period readback copies

  assign req     = cyc & stb & ~ack;  // ack is high for exactly one cycle
  assign offset  = adr[3:0];
  assign chan_ok = (adr[11:8] < 4'(NUM_CHANNELS));
  assign rd_chan = adr[10:8];         // store reads combinationally
  assign wr      = req & we & chan_ok;

  // ----------------------------------------
  // read mux
  always_comb begin
    rd_data = '0;                     // unknown offsets and bad channels read 0
    if (chan_ok) begin
      case (offset)
        REG_OVERFLOW: rd_data = ovf_copy[rd_chan];
        REG_DIVIDE:   rd_data = clk_div;
        REG_SAMPLE:   rd_data = rd_sample;
        REG_SEQUENCE: rd_data = rd_seq;
        REG_ID:       rd_data = ADC_ID;
        REG_BUSY:     rd_data = {15'd0, busy};
        REG_LAST:     rd_data = last_cmd;
        default:      rd_data = '0;
      endcase
    end
  end

  // ----------------------------------------
  // handshake, config registers and strobes
  always_ff @(posedge clk) begin
    if (reset) begin
      ack       <= 1'b0;
      dat_r     <= '0;
      clk_div   <= '0;
      cmd_load  <= 1'b0;
      ovf_write <= 1'b0;
      for (int i = 0; i < NUM_CHANNELS; i++) begin
        ovf_copy[i] <= '0;
      end
    end else begin
      ack       <= req;
      dat_r     <= req ? rd_data : '0;             // valid with ack
      cmd_load  <= wr && (offset == REG_PROGRAM);  // one-cycle strobe
      ovf_write <= wr && (offset == REG_OVERFLOW);
      if (wr && (offset == REG_DIVIDE)) clk_div <= dat_w;
      if (wr && (offset == REG_OVERFLOW)) ovf_copy[rd_chan] <= dat_w;
    end
  end

  // payload beside the strobes
  always_ff @(posedge clk) begin
    if (req) begin
      cmd_word  <= dat_w;
      ovf_chan  <= rd_chan;
      ovf_value <= dat_w;
    end
  end

endmodule

//--- adc_frame_engine.sv
// serial frame engine, makes sclk from clk and runs program and conversion frames against the ADC
`timescale 1ns/1ns

module adc_frame_engine import adc_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  word_t cmd_word,
  input  logic  cmd_load,
  input  word_t clk_div,
  // serial pins
  output logic  sclk,
  output logic  cs_n,
  output logic  din,
  input  logic  dout,
  // results and status
  output word_t rx_word,
  output logic  rx_valid,
  output logic  busy,
  output word_t last_cmd
);

  frame_state_t state;
  word_t        div_cnt;    // clk cycles within the current sclk half-period
  logic         sclk_q;     // free-running sclk phase
  logic         half_tick;
  logic         rise;       // sclk goes high this cycle
  logic         fall;       // sclk goes low this cycle
  logic         in_frame;
  logic [4:0]   bit_cnt;    // rising edges seen in the frame, 0..16
  word_t        tx_shift;   // msb drives din
  word_t        rx_shift;
  word_t        pend_word;  // last word written over the bus
  word_t        sent_word;  // word of the running program frame
  logic         pending;

  // ----------------------------------------
  // sclk generation, half-period is clk_div + 1 cycles
  assign half_tick = (div_cnt >= clk_div);  // >= copes with a divider shrunk mid-count
  assign rise      = half_tick & ~sclk_q;
  assign fall      = half_tick & sclk_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      div_cnt <= '0;
      sclk_q  <= 1'b0;
    end else if (half_tick) begin
      div_cnt <= '0;
      sclk_q  <= ~sclk_q;
    end else begin
      div_cnt <= div_cnt + 16'd1;
    end
  end

  assign in_frame = (state == PROGRAM) || (state == CONVERT);
  assign sclk     = sclk_q & in_frame;  // parked low between frames
  assign din      = tx_shift[15];       // zero outside program frames
  assign rx_word  = rx_shift;
  assign rx_valid = (state == COPY);
  assign busy     = pending | (state == PROGRAM) | (state == WRITEBACK);

  // ----------------------------------------
  // frame state machine, frames open and close on falling ticks
  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= IDLE;
      cs_n     <= 1'b1;
      bit_cnt  <= '0;
      tx_shift <= '0;
      pending  <= 1'b0;
      last_cmd <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (fall) begin  // a full sclk period has passed since cs_n rose
            cs_n    <= 1'b0;
            bit_cnt <= '0;
            if (pending && (pend_word != last_cmd)) begin
              tx_shift  <= pend_word;
              sent_word <= pend_word;
              state     <= PROGRAM;
            end else begin
              pending  <= 1'b0;  // same word already in the chip
              tx_shift <= '0;
              state    <= CONVERT;
            end
          end
        end
        PROGRAM, CONVERT: begin
          if (rise) begin
            bit_cnt  <= bit_cnt + 5'd1;
            rx_shift <= {rx_shift[14:0], dout};  // msb first
          end else if (fall) begin
            if (bit_cnt == 5'd16) begin
              cs_n     <= 1'b1;
              tx_shift <= '0;
              state    <= (state == PROGRAM) ? WRITEBACK : COPY;
            end else begin
              tx_shift <= {tx_shift[14:0], 1'b0};
            end
          end
        end
        COPY: state <= IDLE;
        WRITEBACK: begin
          last_cmd <= sent_word;
          if (pend_word == sent_word) pending <= 1'b0;  // keep a newer word queued
          state <= IDLE;
        end
        default: state <= IDLE;
      endcase
      // a bus write always wins over the clears above
      if (cmd_load) begin
        pending   <= 1'b1;
        pend_word <= cmd_word;
      end
    end
  end

endmodule

//--- adc_sample_store.sv
// per-channel sample store, publishes held conversion words at each channel's rate and serves reads
`timescale 1ns/1ns

module adc_sample_store import adc_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  word_t       rx_word,
  input  logic        rx_valid,
  input  logic        ovf_write,
  input  chan_t       ovf_chan,
  input  word_t       ovf_value,
  // register block reads
  input  chan_t       rd_chan,
  output word_t       rd_sample,
  output seq_t        rd_seq,
  // side port
  input  logic        sample_req,
  input  chan_t       sample_chan,
  output logic [31:0] sample_word,
  output logic        sample_valid
);

  word_t hold   [NUM_CHANNELS]; // latest conversion per channel
  word_t period [NUM_CHANNELS]; // publish interval minus one
  word_t cnt    [NUM_CHANNELS]; // rate counters
  word_t sample [NUM_CHANNELS]; // published words
  seq_t  seq    [NUM_CHANNELS];
  chan_t rx_chan;

  assign rx_chan = rx_word[15:13];  // chip tags every word with its channel

  // ----------------------------------------
  // holding, period and rate counters
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < NUM_CHANNELS; i++) begin
        hold[i]   <= '0;
        period[i] <= '0;
        cnt[i]    <= '0;
        sample[i] <= '0;
        seq[i]    <= '0;
      end
    end else begin
      for (int i = 0; i < NUM_CHANNELS; i++) begin
        if (cnt[i] == period[i]) begin  // interval is period + 1 cycles
          cnt[i]    <= '0;
          sample[i] <= hold[i];
          seq[i]    <= seq[i] + 16'd1;
        end else begin
          cnt[i] <= cnt[i] + 16'd1;
        end
      end
      if (rx_valid) hold[rx_chan] <= rx_word;
      if (ovf_write) begin
        period[ovf_chan] <= ovf_value;
        cnt[ovf_chan]    <= '0;  // restart so a smaller period takes effect at once
      end
    end
  end

  assign rd_sample = sample[rd_chan];
  assign rd_seq    = seq[rd_chan];

  // ----------------------------------------
  // side port, pair registered one cycle after the request
  always_ff @(posedge clk) begin
    if (reset) begin
      sample_valid <= 1'b0;
    end else begin
      sample_valid <= sample_req;
    end
  end

  always_ff @(posedge clk) begin
    if (sample_req) sample_word <= {seq[sample_chan], sample[sample_chan]};  // seq high
  end

endmodule

//--- adc_control_top.sv
// top level of the ADC controller, ties the bus registers, frame engine and sample store together
`timescale 1ns/1ns

module adc_control_top import adc_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  // wishbone slave
  input  logic        cyc,
  input  logic        stb,
  input  logic        we,
  input  reg_addr_t   adr,
  input  word_t       dat_w,
  output logic        ack,
  output word_t       dat_r,
  // serial pins
  output logic        sclk,
  output logic        cs_n,
  output logic        din,
  input  logic        dout,
  // sample side port
  input  logic        sample_req,
  input  chan_t       sample_chan,
  output logic [31:0] sample_word,
  output logic        sample_valid
);

  word_t cmd_word;
  logic  cmd_load;
  word_t clk_div;
  logic  busy;
  word_t last_cmd;
  word_t rx_word;
  logic  rx_valid;
  logic  ovf_write;
  chan_t ovf_chan;
  word_t ovf_value;
  chan_t rd_chan;
  word_t rd_sample;
  seq_t  rd_seq;

  adc_bus_regs u_regs (
    .clk       (clk),
    .reset     (reset),
    .cyc       (cyc),
    .stb       (stb),
    .we        (we),
    .adr       (adr),
    .dat_w     (dat_w),
    .ack       (ack),
    .dat_r     (dat_r),
    .cmd_word  (cmd_word),
    .cmd_load  (cmd_load),
    .clk_div   (clk_div),
    .busy      (busy),
    .last_cmd  (last_cmd),
    .ovf_write (ovf_write),
    .ovf_chan  (ovf_chan),
    .ovf_value (ovf_value),
    .rd_chan   (rd_chan),
    .rd_sample (rd_sample),
    .rd_seq    (rd_seq)
  );

  adc_frame_engine u_engine (
    .clk      (clk),
    .reset    (reset),
    .cmd_word (cmd_word),
    .cmd_load (cmd_load),
    .clk_div  (clk_div),
    .sclk     (sclk),
    .cs_n     (cs_n),
    .din      (din),
    .dout     (dout),
    .rx_word  (rx_word),
    .rx_valid (rx_valid),
    .busy     (busy),
    .last_cmd (last_cmd)
  );

  adc_sample_store u_store (
    .clk          (clk),
    .reset        (reset),
    .rx_word      (rx_word),
    .rx_valid     (rx_valid),
    .ovf_write    (ovf_write),
    .ovf_chan     (ovf_chan),
    .ovf_value    (ovf_value),
    .rd_chan      (rd_chan),
    .rd_sample    (rd_sample),
    .rd_seq       (rd_seq),
    .sample_req   (sample_req),
    .sample_chan  (sample_chan),
    .sample_word  (sample_word),
    .sample_valid (sample_valid)
  );

endmodule

//--- tb_adc_chip.sv
// behavioural serial ADC for the controller testbench, takes program words and returns tagged samples
`timescale 1ns/1ns

module tb_adc_chip import adc_pkg::*; (
  input  logic sclk,
  input  logic cs_n,
  input  logic din,
  output logic dout
);

  int    seed;
  chan_t chan;        // channel for the coming conversions
  word_t word;        // word returned in the current frame
  word_t tx;
  word_t rx;
  word_t last_prog;   // last program word taken in
  bit    returned [0:7][0:8191];  // every conversion word handed out, by channel and data

  // ----------------------------------------
  // one frame per pass, din in on rising sclk, dout out on falling sclk
  initial begin
    seed      = 32'h8fea;
    chan      = '0;
    last_prog = '0;
    dout      = 1'b0;
    forever begin
      @(negedge cs_n);
      word = {chan, 13'($random(seed))};  // channel tag on top, data below
      tx   = word;
      rx   = '0;
      dout = tx[15];                      // msb ready before the first rising edge
      repeat (16) begin
        @(posedge sclk);
        rx = {rx[14:0], din};
        @(negedge sclk);
        tx   = {tx[14:0], 1'b0};
        dout = tx[15];
      end
      if (!cs_n) @(posedge cs_n);
      // a nonzero word on din is a program frame, an all-zero one a conversion
      if (rx != 16'h0) begin
        last_prog = rx;
        chan      = rx[12:10];
      end else begin
        returned[word[15:13]][word[12:0]] = 1'b1;
      end
    end
  end

endmodule

//--- tb_adc_control.sv
// top-level testbench that drives the ADC controller over wishbone and the side port against a model
`timescale 1ns/1ns

module tb_adc_control import adc_pkg::*; ();

  logic        clk;
  logic        reset;
  logic        cyc;
  logic        stb;
  logic        we;
  reg_addr_t   adr;
  word_t       dat_w;
  logic        ack;
  word_t       dat_r;
  logic        sclk;
  logic        cs_n;
  logic        din;
  logic        dout;
  logic        sample_req;
  chan_t       sample_chan;
  logic [31:0] sample_word;
  logic        sample_valid;

  int    seed;
  word_t div_model;                   // expected REG_DIVIDE
  word_t period_model [NUM_CHANNELS]; // expected REG_OVERFLOW per channel
  word_t prog_model;                  // last word the chip should hold

  adc_control_top uut (.*);
  tb_adc_chip chip (.sclk(sclk), .cs_n(cs_n), .din(din), .dout(dout));

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ----------------------------------------
  // checking and bus helpers
  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
      $display("Simulation failed");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  task automatic fail_timeout(input string what);
    $display("timeout while waiting for %s", what);
    $display("Simulation failed");
    $fatal(1, "wait limit exceeded");
  endtask

  function automatic reg_addr_t reg_addr(input logic [3:0] ch, input logic [3:0] off);
    return {ch, 4'h0, off};  // channel in 11..8, offset in 3..0
  endfunction

  task automatic bus_access(input logic write, input reg_addr_t a, input word_t d,
                            output word_t q);
    int t;
    @(posedge clk);
    cyc   <= 1'b1;
    stb   <= 1'b1;
    we    <= write;
    adr   <= a;
    dat_w <= d;
    t = 0;
    @(negedge clk);
    while (!ack && t < 8) begin  // ack due one cycle after the request
      t++;
      @(negedge clk);
    end
    if (!ack) fail_timeout("the wishbone ack");
    q = dat_r;
    @(posedge clk);
    cyc <= 1'b0;
    stb <= 1'b0;
    we  <= 1'b0;
  endtask

  task automatic read_check(input string name, input reg_addr_t a, input word_t expected);
    word_t q;
    bus_access(1'b0, a, '0, q);
    check_value(name, 32'(q), 32'(expected));
  endtask

  // ----------------------------------------
  // register map, readback and out-of-range channels
  task automatic check_registers();
    word_t q;
    read_check("REG_ID", reg_addr(4'd0, REG_ID), ADC_ID);
    read_check("REG_BUSY", reg_addr(4'd0, REG_BUSY), 16'h0);
    read_check("REG_LAST", reg_addr(4'd0, REG_LAST), 16'h0);
    div_model = 16'($random(seed));
    bus_access(1'b1, reg_addr(4'd0, REG_DIVIDE), div_model, q);
    read_check("REG_DIVIDE", reg_addr(4'd5, REG_DIVIDE), div_model);
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      period_model[c] = 16'($random(seed));
      bus_access(1'b1, reg_addr(4'(c), REG_OVERFLOW), period_model[c], q);
    end
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      read_check("REG_OVERFLOW", reg_addr(4'(c), REG_OVERFLOW), period_model[c]);
    end
    bus_access(1'b1, reg_addr(4'd9, REG_DIVIDE), ~div_model, q);  // must be dropped
    read_check("REG_DIVIDE", reg_addr(4'd0, REG_DIVIDE), div_model);
    for (int c = 8; c < 16; c++) begin
      read_check("REG_ID out of range", reg_addr(4'(c), REG_ID), 16'h0);
      read_check("REG_DIVIDE out of range", reg_addr(4'(c), REG_DIVIDE), 16'h0);
    end
    div_model = 16'($random(seed) & 32'h3);  // fast sclk for the frame tests
    bus_access(1'b1, reg_addr(4'd0, REG_DIVIDE), div_model, q);
  endtask

  // ----------------------------------------
  // program word that selects the conversion channel
  task automatic program_channel(input chan_t ch);
    word_t w;
    word_t q;
    int    t;
    w = prog_model;
    while (w == prog_model || w == 16'h0) begin
      w = {3'($random(seed)), ch, 10'($random(seed))};  // bits 12..10 pick the channel
    end
    prog_model = w;
    bus_access(1'b1, reg_addr(4'd0, REG_PROGRAM), w, q);
    t = 0;
    q = 16'h1;
    while (q != 16'h0 && t < 2000) begin
      bus_access(1'b0, reg_addr(4'd0, REG_BUSY), '0, q);
      t++;
    end
    if (q != 16'h0) fail_timeout("REG_BUSY to clear after a program write");
    read_check("REG_LAST", reg_addr(4'd0, REG_LAST), w);
    check_value("chip program word", 32'(chip.last_prog), 32'(w));
  endtask

  // samples against the chip log and sequence number growth
  task automatic sample_channel(input chan_t ch);
    word_t p;
    word_t q;
    seq_t  prev;
    seq_t  s0;
    seq_t  s1;
    seq_t  grow;
    int    hits;
    p = 16'd40 + 16'($random(seed) & 32'h3f);
    period_model[ch] = p;
    bus_access(1'b1, reg_addr({1'b0, ch}, REG_OVERFLOW), p, q);
    read_check("REG_OVERFLOW", reg_addr({1'b0, ch}, REG_OVERFLOW), period_model[ch]);
    prev = '0;
    hits = 0;
    for (int n = 0; n < 12; n++) begin
      repeat (int'(p)) @(posedge clk);
      bus_access(1'b0, reg_addr({1'b0, ch}, REG_SAMPLE), '0, q);
      if (q != 16'h0) begin
        hits++;
        check_value("REG_SAMPLE channel bits", 32'(q[15:13]), 32'(ch));
        check_value("REG_SAMPLE chip word", 32'(chip.returned[ch][q[12:0]]), 32'd1);
      end
      bus_access(1'b0, reg_addr({1'b0, ch}, REG_SEQUENCE), '0, s0);
      check_value("REG_SEQUENCE not decreasing", 32'(s0 >= prev), 32'd1);
      prev = s0;
    end
    check_value("nonzero REG_SAMPLE seen", 32'(hits > 0), 32'd1);
    bus_access(1'b0, reg_addr({1'b0, ch}, REG_SEQUENCE), '0, s0);
    repeat (10 * (int'(p) + 1)) @(posedge clk);  // ten periods
    bus_access(1'b0, reg_addr({1'b0, ch}, REG_SEQUENCE), '0, s1);
    grow = s1 - s0;
    check_value("REG_SEQUENCE growth 8..11", 32'(grow >= 16'd8 && grow <= 16'd11), 32'd1);
  endtask

  // side port pair against the frozen bus view
  task automatic side_port_check(input chan_t ch);
    word_t q;
    seq_t  s;
    word_t d;
    period_model[ch] = 16'hFFFF;
    bus_access(1'b1, reg_addr({1'b0, ch}, REG_OVERFLOW), 16'hFFFF, q);
    read_check("REG_OVERFLOW", reg_addr({1'b0, ch}, REG_OVERFLOW), period_model[ch]);
    bus_access(1'b0, reg_addr({1'b0, ch}, REG_SEQUENCE), '0, s);
    bus_access(1'b0, reg_addr({1'b0, ch}, REG_SAMPLE), '0, d);
    @(posedge clk);
    sample_req  <= 1'b1;
    sample_chan <= ch;
    @(negedge clk);
    check_value("sample_valid", 32'(sample_valid), 32'd0);  // not before the next edge
    @(posedge clk);
    sample_req <= 1'b0;
    @(negedge clk);
    check_value("sample_valid", 32'(sample_valid), 32'd1);
    check_value("sample_word", sample_word, {s, d});         // sequence high, sample low
  endtask

  // ----------------------------------------
  // main sequence
  initial begin
    seed        = 32'h8fea;
    prog_model  = '0;
    reset       = 1'b1;
    cyc         = 1'b0;
    stb         = 1'b0;
    we          = 1'b0;
    adr         = '0;
    dat_w       = '0;
    sample_req  = 1'b0;
    sample_chan = '0;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    check_registers();
    for (int n = 0; n < 3; n++) begin
      chan_t ch;
      ch = 3'($random(seed));
      program_channel(ch);
      sample_channel(ch);
    end
    for (int n = 0; n < 3; n++) begin
      side_port_check(3'($random(seed)));
    end
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

//--- files.f
adc_pkg.sv
adc_bus_regs.sv
adc_frame_engine.sv
adc_sample_store.sv
adc_control_top.sv
tb_adc_chip.sv
tb_adc_control.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module tb_adc_control -f files.f -o sim_adc &&
./obj_dir/sim_adc || { echo "simulation run reported an error"; exit 1; }
